/* limb_link.f */
+incdir+rtl
rtl/limb_types_pkg.sv
rtl/spi_link_pkg.sv
rtl/length_playback.sv
rtl/spi_length_tx.sv
rtl/spi_rate_rx.sv
rtl/link_frame_combine.sv
rtl/limb_link_top.sv
tests/tb_limb_link.sv

/* rtl/length_playback.sv */
`timescale 1ns/1ps
`include "limb_link_cfg.svh"

module length_playback
(
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        reset_sim,
    input  logic                        host_write,
    input  logic [`LIMB_HALF_W-1:0]     host_half,
    input  logic                        tick_load,
    input  logic [`LIMB_TICK_W-1:0]     tick_period,
    output logic                        tick,
    output limb_types_pkg::length_t     cur_length
);
    import limb_types_pkg::*;

    localparam int PTR_W = $clog2(`LIMB_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = `LIMB_DEPTH;
    localparam logic [`LIMB_TICK_W-1:0] TICK_DEFAULT = `LIMB_TICK_DEFAULT;

    // host side
    logic                       half_pending;
    logic [`LIMB_HALF_W-1:0]    low_half;
    logic [PTR_W:0]             wr_count;
    logic                       mem_we;
    length_t                    sample_mem [`LIMB_DEPTH];

    // replay side
    logic [`LIMB_TICK_W-1:0]    period_q;
    logic [`LIMB_TICK_W-1:0]    tick_cnt;
    logic                       count_end;
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W:0]             rd_next;

    //////////////////////////////////////////////////////////////////////
    // host writes, low half then high half
    //////////////////////////////////////////////////////////////////////

    // second half completes a sample, dropped once memory is full
    assign mem_we = host_write & half_pending & (wr_count < DEPTH_CNT);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            half_pending <= 1'b0;
            wr_count     <= '0;
        end
        else if (host_write)
        begin
            half_pending <= ~half_pending;
            if (mem_we)
                wr_count <= wr_count + 1'b1;
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (host_write & ~half_pending)
            low_half <= host_half;
        if (mem_we)
            sample_mem[wr_count[PTR_W-1:0]] <= {host_half, low_half};
    end

    //////////////////////////////////////////////////////////////////////
    // simulation tick and replay pointer
    //////////////////////////////////////////////////////////////////////

    // new period only used at the next reload
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            period_q <= TICK_DEFAULT;
        else if (tick_load)
            period_q <= tick_period;
    end

    assign count_end = (tick_cnt == '0);
    assign rd_next   = {1'b0, rd_ptr} + 1'b1;

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            tick_cnt   <= TICK_DEFAULT - 1'b1;
            tick       <= 1'b0;
            rd_ptr     <= '0;
            cur_length <= '0;
        end
        else if (reset_sim)
        begin
            // restart replay, samples stay
            tick_cnt <= period_q - 1'b1;
            tick     <= 1'b0;
            rd_ptr   <= '0;
        end
        else
        begin
            tick <= count_end;
            if (count_end)
            begin
                tick_cnt <= period_q - 1'b1;
                // nothing stored yet
                if (wr_count == '0)
                    cur_length <= '0;
                else
                begin
                    cur_length <= sample_mem[rd_ptr];
                    // wrap at stored count, not at depth
                    rd_ptr <= (rd_next == wr_count) ? '0 : rd_next[PTR_W-1:0];
                end
            end
            else
                tick_cnt <= tick_cnt - 1'b1;
        end
    end

    // tick must stay a single-cycle strobe for tx and combiner
    tick_single_cycle: assert property (
        @(posedge ep50trig) disable iff (reset_global) tick |=> !tick
    ) else $error("length_playback: tick high on two consecutive cycles");

endmodule

/* rtl/limb_link_cfg.svh */
`ifndef LIMB_LINK_CFG_SVH
`define LIMB_LINK_CFG_SVH

//////////////////////////////////////////////////////////////////////
// data widths
//////////////////////////////////////////////////////////////////////

// one muscle-length sample or one Ia rate word
`define LIMB_SAMPLE_W 32

// host delivers samples in halves of this width
`define LIMB_HALF_W 16

//////////////////////////////////////////////////////////////////////
// playback and link timing
//////////////////////////////////////////////////////////////////////

// playback memory entries
`define LIMB_DEPTH 16

// clocks per half sck period
`define LIMB_SPI_DIV 4

// tick period and tick index width
`define LIMB_TICK_W 16

// tick period after reset, in clocks
`define LIMB_TICK_DEFAULT 400

`endif

/* rtl/limb_link_top.sv */
`timescale 1ns/1ps
`include "limb_link_cfg.svh"

module limb_link_top
(
    input  logic                            ep50trig,
    input  logic                            reset_global,
    input  logic                            reset_sim,
    input  logic                            host_write,
    input  logic [`LIMB_HALF_W-1:0]         host_half,
    input  logic                            tick_load,
    input  logic [`LIMB_TICK_W-1:0]         tick_period,
    input  spi_link_pkg::spi_bus_t          rate_bus,
    output spi_link_pkg::spi_bus_t          length_bus,
    output limb_types_pkg::link_frame_t     frame,
    output logic                            frame_valid
);
    import limb_types_pkg::*;

    logic       tick;
    length_t    cur_length;
    rate_t      rx_word;
    logic       rx_done;

    //////////////////////////////////////////////////////////////////////
    // stimulus replay and outgoing length link
    //////////////////////////////////////////////////////////////////////

    length_playback u_playback
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .host_write   (host_write),
        .host_half    (host_half),
        .tick_load    (tick_load),
        .tick_period  (tick_period),
        .tick         (tick),
        .cur_length   (cur_length)
    );

    spi_length_tx u_length_tx
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .tick         (tick),
        .cur_length   (cur_length),
        .length_bus   (length_bus)
    );

    // Ia rate from the spindle board
    spi_rate_rx u_rate_rx
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .rate_bus     (rate_bus),
        .rx_word      (rx_word),
        .rx_done      (rx_done)
    );

    link_frame_combine u_combine
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .tick         (tick),
        .cur_length   (cur_length),
        .rx_word      (rx_word),
        .rx_done      (rx_done),
        .frame        (frame),
        .frame_valid  (frame_valid)
    );

endmodule

/* rtl/limb_types_pkg.sv */
`include "limb_link_cfg.svh"

package limb_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // scalar words on the limb link
    //////////////////////////////////////////////////////////////////////

    // muscle length, raw 32-bit word from host
    typedef logic [`LIMB_SAMPLE_W-1:0] length_t;

    // Ia firing rate from spindle board
    typedef logic [`LIMB_SAMPLE_W-1:0] rate_t;

    // running simulation tick number
    typedef logic [`LIMB_TICK_W-1:0] tick_idx_t;

    //////////////////////////////////////////////////////////////////////
    // per-tick frame
    //////////////////////////////////////////////////////////////////////

    // msb first: length, rate, tick index, received word count
    typedef struct packed
    {
        length_t    length;
        rate_t      rate;
        tick_idx_t  tick_index;
        // wraps at 8 bits
        logic [7:0] rx_count;
    } link_frame_t;

endpackage

/* rtl/link_frame_combine.sv */
`timescale 1ns/1ps

module link_frame_combine
(
    input  logic                            ep50trig,
    input  logic                            reset_global,
    input  logic                            reset_sim,
    input  logic                            tick,
    input  limb_types_pkg::length_t         cur_length,
    input  limb_types_pkg::rate_t           rx_word,
    input  logic                            rx_done,
    output limb_types_pkg::link_frame_t     frame,
    output logic                            frame_valid
);
    import limb_types_pkg::*;

    rate_t      held_rate;
    logic [7:0] rx_count;
    tick_idx_t  tick_idx;

    // word landing on the tick cycle still counts for that tick
    rate_t      rate_now;
    logic [7:0] count_now;

    assign rate_now  = rx_done ? rx_word : held_rate;
    assign count_now = rx_done ? rx_count + 1'b1 : rx_count;

    //////////////////////////////////////////////////////////////////////
    // latest rate and per-tick frame
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            held_rate   <= '0;
            rx_count    <= '0;
            tick_idx    <= '0;
            frame       <= '0;
            frame_valid <= 1'b0;
        end
        else if (reset_sim)
        begin
            held_rate   <= '0;
            rx_count    <= '0;
            tick_idx    <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            held_rate   <= rate_now;
            rx_count    <= count_now;
            frame_valid <= tick;
            if (tick)
            begin
                frame    <= '{length: cur_length, rate: rate_now,
                              tick_index: tick_idx, rx_count: count_now};
                tick_idx <= tick_idx + 1'b1;
            end
        end
    end

endmodule

/* rtl/spi_length_tx.sv */
`timescale 1ns/1ps
`include "limb_link_cfg.svh"

module spi_length_tx
(
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  logic                        tick,
    input  limb_types_pkg::length_t     cur_length,
    output spi_link_pkg::spi_bus_t      length_bus
);
    import limb_types_pkg::*;
    import spi_link_pkg::*;

    localparam int DIV_W = $clog2(`LIMB_SPI_DIV + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = `LIMB_SPI_DIV - 1;
    // 2 half periods per bit
    localparam logic [5:0] HALF_LAST = 2 * `LIMB_SAMPLE_W - 1;

    logic               busy;
    // trailing half period before ssel rises
    logic               tail;
    logic [DIV_W-1:0]   div_cnt;
    logic [5:0]         half_cnt;
    length_t            shreg;

    //////////////////////////////////////////////////////////////////////
    // spi master, mode 0, msb first
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            busy       <= 1'b0;
            tail       <= 1'b0;
            div_cnt    <= '0;
            half_cnt   <= '0;
            length_bus <= SPI_IDLE;
        end
        else if (!busy)
        begin
            // start frame, first bit ready before first rise
            if (tick)
            begin
                busy            <= 1'b1;
                tail            <= 1'b0;
                div_cnt         <= '0;
                half_cnt        <= '0;
                length_bus.ssel <= 1'b0;
                length_bus.sck  <= 1'b0;
                length_bus.mosi <= cur_length[`LIMB_SAMPLE_W-1];
            end
        end
        else if (div_cnt == DIV_LAST)
        begin
            div_cnt <= '0;
            if (tail)
            begin
                busy            <= 1'b0;
                tail            <= 1'b0;
                length_bus.ssel <= 1'b1;
            end
            else
            begin
                length_bus.sck <= ~length_bus.sck;
                // falling edge, present next bit
                if (length_bus.sck)
                    length_bus.mosi <= shreg[`LIMB_SAMPLE_W-2];
                if (half_cnt == HALF_LAST)
                    tail <= 1'b1;
                half_cnt <= half_cnt + 1'b1;
            end
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // payload shifter, zeros shift in so mosi idles low
    always_ff @(posedge ep50trig)
    begin
        if (!busy && tick)
            shreg <= cur_length;
        else if (busy && !tail && div_cnt == DIV_LAST && length_bus.sck)
            shreg <= {shreg[`LIMB_SAMPLE_W-2:0], 1'b0};
    end

    // tick period too short for one frame
    no_tick_while_busy: assert property (
        @(posedge ep50trig) disable iff (reset_global) tick |-> !busy
    ) else $error("spi_length_tx: tick dropped, frame still in progress");

endmodule

/* rtl/spi_link_pkg.sv */
package spi_link_pkg;

    //////////////////////////////////////////////////////////////////////
    // spi pin bundle
    //////////////////////////////////////////////////////////////////////

    // three wires per direction, no miso on this link
    typedef struct packed
    {
        logic sck;
        logic mosi;
        // active low select
        logic ssel;
    } spi_bus_t;

    // bus at rest, clock low and slave deselected
    localparam spi_bus_t SPI_IDLE = '{
        sck:  1'b0,
        mosi: 1'b0,
        ssel: 1'b1
    };

endpackage

/* rtl/spi_rate_rx.sv */
`timescale 1ns/1ps
`include "limb_link_cfg.svh"

module spi_rate_rx
(
    input  logic                        ep50trig,
    input  logic                        reset_global,
    input  spi_link_pkg::spi_bus_t      rate_bus,
    output limb_types_pkg::rate_t       rx_word,
    output logic                        rx_done
);
    import limb_types_pkg::*;
    import spi_link_pkg::*;

    localparam logic [5:0] LAST_BIT = `LIMB_SAMPLE_W - 1;

    // two-flop synchronizer, then one more stage for edge detect
    spi_bus_t   bus_meta;
    spi_bus_t   bus_sync;
    spi_bus_t   bus_prev;

    logic       sck_rise;
    logic       shift_en;
    logic       word_end;
    logic [5:0] bit_cnt;
    rate_t      shreg;

    //////////////////////////////////////////////////////////////////////
    // synchronize peer pins
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            bus_meta <= SPI_IDLE;
            bus_sync <= SPI_IDLE;
            bus_prev <= SPI_IDLE;
        end
        else
        begin
            bus_meta <= rate_bus;
            bus_sync <= bus_meta;
            bus_prev <= bus_sync;
        end
    end

    assign sck_rise = bus_sync.sck & ~bus_prev.sck;
    assign shift_en = sck_rise & ~bus_sync.ssel;
    assign word_end = shift_en & (bit_cnt == LAST_BIT);

    //////////////////////////////////////////////////////////////////////
    // bit count and word strobe
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            bit_cnt <= '0;
            rx_done <= 1'b0;
        end
        else
        begin
            rx_done <= word_end;
            // deselect drops a partial word
            if (bus_sync.ssel || word_end)
                bit_cnt <= '0;
            else if (shift_en)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // msb arrives first
    always_ff @(posedge ep50trig)
    begin
        if (bus_sync.ssel)
            shreg <= '0;
        else if (shift_en)
            shreg <= {shreg[`LIMB_SAMPLE_W-2:0], bus_sync.mosi};
        if (word_end)
            rx_word <= {shreg[`LIMB_SAMPLE_W-2:0], bus_sync.mosi};
    end

    // word strobe only inside a selected frame
    done_inside_frame: assert property (
        @(posedge ep50trig) disable iff (reset_global) rx_done |-> !bus_sync.ssel
    ) else $error("spi_rate_rx: rx_done outside an active frame");

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the limb link testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_limb_link -f limb_link.f -o tb_limb_link_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_limb_link_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
echo "pass message not found"
exit 1

/* tests/tb_limb_link.sv */
`timescale 1ns/1ps
`include "limb_link_cfg.svh"

module tb_limb_link;
    import limb_types_pkg::*;
    import spi_link_pkg::*;

    localparam int CLK_HALF      = 20;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 5;
    localparam int NUM_SAMPLES   = 6;
    // peer sck half period in clocks
    localparam int PEER_HALF     = 3;
    localparam int NEW_PERIOD    = 300;
    localparam int FRAME_TIMEOUT = 2 * `LIMB_TICK_DEFAULT;
    localparam int DRAIN_TIMEOUT = 1000;
    localparam logic [31:0] RNG_SEED = 32'h1beb1fca;

    // dut pins
    logic                       ep50trig;
    logic                       reset_global;
    logic                       reset_sim;
    logic                       host_write;
    logic [`LIMB_HALF_W-1:0]    host_half;
    logic                       tick_load;
    logic [`LIMB_TICK_W-1:0]    tick_period;
    spi_bus_t                   rate_bus;
    spi_bus_t                   length_bus;
    link_frame_t                frame;
    logic                       frame_valid;

    // reference model of the frame stream
    length_t    samples [NUM_SAMPLES];
    length_t    exp_length;
    length_t    first_sample;
    int         exp_slot;
    tick_idx_t  exp_index;
    rate_t      exp_rate;
    logic [7:0] exp_count;
    logic       restart_seen;
    int         frames_seen;
    length_t    tx_expect [$];

    // tick spacing
    int         gap_cnt;
    int         exp_gap;
    logic       gap_check;

    // length link decoder
    spi_bus_t   prev_bus;
    length_t    word_shift;
    length_t    word_got;
    length_t    word_exp;
    int         word_bits;
    logic       word_done;
    logic       word_had_exp;
    int         words_checked;

    assign exp_length   = samples[exp_slot];
    assign first_sample = samples[0];

    limb_link_top dut0
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .host_write   (host_write),
        .host_half    (host_half),
        .tick_load    (tick_load),
        .tick_period  (tick_period),
        .rate_bus     (rate_bus),
        .length_bus   (length_bus),
        .frame        (frame),
        .frame_valid  (frame_valid)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #CLK_HALF ep50trig = ~ep50trig;
    end

    //////////////////////////////////////////////////////////////////////
    // failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        abort_run();
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // inputs change just after the edge
    task automatic next_cycle(input int n);
        repeat (n) @(posedge ep50trig);
        #DRIVE_DLY;
    endtask

    task automatic wait_frame();
        int waited;
        waited = 0;
        @(posedge ep50trig);
        while (!frame_valid)
        begin
            waited++;
            if (waited > FRAME_TIMEOUT)
                report_timeout("frame_valid");
            @(posedge ep50trig);
        end
        #DRIVE_DLY;
    endtask

    // low half first, then high half
    task automatic write_sample(input length_t value);
        host_write = 1'b1;
        host_half  = value[`LIMB_HALF_W-1:0];
        next_cycle(1);
        host_half  = value[`LIMB_SAMPLE_W-1:`LIMB_HALF_W];
        next_cycle(1);
        host_write = 1'b0;
    endtask

    // peer board, mode 0, msb first, may stop early
    task automatic send_rate(input rate_t word, input int nbits);
        int i;
        rate_bus.ssel = 1'b0;
        next_cycle(PEER_HALF);
        for (i = 0; i < nbits; i++)
        begin
            rate_bus.mosi = word[`LIMB_SAMPLE_W-1-i];
            next_cycle(PEER_HALF);
            rate_bus.sck = 1'b1;
            next_cycle(PEER_HALF);
            rate_bus.sck = 1'b0;
        end
        next_cycle(PEER_HALF);
        rate_bus.ssel = 1'b1;
        rate_bus.mosi = 1'b0;
        // only a whole word updates the held rate
        if (nbits == `LIMB_SAMPLE_W)
        begin
            exp_rate  = word;
            exp_count = exp_count + 1'b1;
        end
    endtask

    task automatic drain_length_link();
        int waited;
        waited = 0;
        @(posedge ep50trig);
        while (words_checked != frames_seen)
        begin
            waited++;
            if (waited > DRAIN_TIMEOUT)
                report_timeout("the last length link word");
            @(posedge ep50trig);
        end
        #DRIVE_DLY;
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model and length link decoder
    //////////////////////////////////////////////////////////////////////

    always @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            exp_slot     <= 0;
            exp_index    <= '0;
            restart_seen <= 1'b0;
            frames_seen  <= 0;
        end
        else if (reset_sim)
        begin
            exp_slot     <= 0;
            exp_index    <= '0;
            restart_seen <= 1'b1;
        end
        else if (frame_valid)
        begin
            // word the length link owes for this tick
            tx_expect.push_back(exp_length);
            exp_slot     <= (exp_slot == NUM_SAMPLES - 1) ? 0 : exp_slot + 1;
            exp_index    <= exp_index + 1'b1;
            restart_seen <= 1'b0;
            frames_seen  <= frames_seen + 1;
        end
    end

    // clocks since the last frame
    always @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            gap_cnt <= 0;
        else if (frame_valid)
            gap_cnt <= 1;
        else
            gap_cnt <= gap_cnt + 1;
    end

    always @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            prev_bus      <= SPI_IDLE;
            word_shift    <= '0;
            word_got      <= '0;
            word_exp      <= '0;
            word_bits     <= 0;
            word_done     <= 1'b0;
            word_had_exp  <= 1'b0;
            words_checked <= 0;
        end
        else
        begin
            prev_bus  <= length_bus;
            word_done <= 1'b0;
            if (prev_bus.ssel && !length_bus.ssel)
            begin
                word_shift <= '0;
                word_bits  <= 0;
            end
            else if (!length_bus.ssel && length_bus.sck && !prev_bus.sck)
            begin
                // sample on sck rise
                word_shift <= {word_shift[`LIMB_SAMPLE_W-2:0], length_bus.mosi};
                word_bits  <= word_bits + 1;
            end
            else if (!prev_bus.ssel && length_bus.ssel)
            begin
                word_done     <= 1'b1;
                word_got      <= word_shift;
                words_checked <= words_checked + 1;
                word_had_exp  <= (tx_expect.size() != 0);
                if (tx_expect.size() != 0)
                    word_exp <= tx_expect.pop_front();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    reset_idle: assert property (@(posedge ep50trig)
        reset_global |-> length_bus == SPI_IDLE && !frame_valid && frame == '0)
    else
    begin
        $display("outputs are not idle while reset_global is high");
        abort_run();
    end

    replay_length: assert property (@(posedge ep50trig) disable iff (reset_global)
        frame_valid |-> frame.length == exp_length)
    else report_mismatch("replay length", $sampled(exp_length), $sampled(frame.length));

    replay_index: assert property (@(posedge ep50trig) disable iff (reset_global)
        frame_valid |-> frame.tick_index == exp_index)
    else report_mismatch("tick index", $sampled(exp_index), $sampled(frame.tick_index));

    rate_value: assert property (@(posedge ep50trig) disable iff (reset_global)
        frame_valid |-> frame.rate == exp_rate)
    else report_mismatch("rate value", $sampled(exp_rate), $sampled(frame.rate));

    rate_count: assert property (@(posedge ep50trig) disable iff (reset_global)
        frame_valid |-> frame.rx_count == exp_count)
    else report_mismatch("rx count", $sampled(exp_count), $sampled(frame.rx_count));

    // first frame after reset_sim restarts from sample 0
    restart_frame: assert property (@(posedge ep50trig) disable iff (reset_global)
        frame_valid && restart_seen |-> frame.length == first_sample)
    else report_mismatch("restart length", $sampled(first_sample), $sampled(frame.length));

    length_word: assert property (@(posedge ep50trig) disable iff (reset_global)
        word_done |-> word_got == word_exp)
    else report_mismatch("length link word", $sampled(word_exp), $sampled(word_got));

    length_bits: assert property (@(posedge ep50trig) disable iff (reset_global)
        word_done |-> word_bits == `LIMB_SAMPLE_W)
    else report_mismatch("length link bit count", `LIMB_SAMPLE_W, $sampled(word_bits));

    length_orphan: assert property (@(posedge ep50trig) disable iff (reset_global)
        word_done |-> word_had_exp)
    else
    begin
        $display("length link sent a word that no tick started");
        abort_run();
    end

    tick_spacing: assert property (@(posedge ep50trig) disable iff (reset_global)
        frame_valid && gap_check |-> gap_cnt == exp_gap)
    else report_mismatch("tick spacing", $sampled(exp_gap), $sampled(gap_cnt));

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int i;
        void'($urandom(RNG_SEED));
        reset_global = 1'b1;
        reset_sim    = 1'b0;
        host_write   = 1'b0;
        host_half    = '0;
        tick_load    = 1'b0;
        tick_period  = '0;
        rate_bus     = SPI_IDLE;
        exp_rate     = '0;
        exp_count    = '0;
        exp_gap      = `LIMB_TICK_DEFAULT;
        gap_check    = 1'b0;
        for (i = 0; i < NUM_SAMPLES; i++)
            samples[i] = $urandom;
        next_cycle(RESET_CYCLES);
        reset_global = 1'b0;

        // fill playback memory before the first tick
        for (i = 0; i < NUM_SAMPLES; i++)
            write_sample(samples[i]);
        wait_frame();
        gap_check = 1'b1;

        // full peer words
        for (i = 0; i < 3; i++)
        begin
            send_rate($urandom, `LIMB_SAMPLE_W);
            wait_frame();
        end

        // peer stops early, then a clean word
        send_rate($urandom, 19);
        wait_frame();
        send_rate($urandom, `LIMB_SAMPLE_W);
        wait_frame();

        // run past the end of the stored samples, stop mid-loop
        repeat (NUM_SAMPLES + 1) wait_frame();

        // replay restart keeps the samples
        gap_check = 1'b0;
        reset_sim = 1'b1;
        next_cycle(1);
        reset_sim = 1'b0;
        exp_rate  = '0;
        exp_count = '0;
        wait_frame();
        wait_frame();

        // running count ends on the old period
        tick_load   = 1'b1;
        tick_period = NEW_PERIOD;
        next_cycle(1);
        tick_load   = 1'b0;
        wait_frame();
        exp_gap   = NEW_PERIOD;
        gap_check = 1'b1;
        send_rate($urandom, `LIMB_SAMPLE_W);
        wait_frame();
        repeat (3) wait_frame();

        drain_length_link();
        next_cycle(2);
        if (frames_seen >= 2 * NUM_SAMPLES && words_checked == frames_seen)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
        begin
            $display("too few frames or length link words were checked");
            abort_run();
        end
    end

endmodule
